/* Bender.yml */
package:
  name: arcade_input

sources:
  - arcade_pkg.sv
  - key_decoder.sv
  - encoder_tracker.sv
  - spinner_drive.sv
  - dip_bank.sv
  - input_ctrl.sv
  - arcade_input_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_arcade_input.sv

/* arcade_input_top.sv */
// Arcade cabinet input block
`timescale 1ns/1ps
`default_nettype none

module arcade_input_top (
	input  wire                   CLK_48M,
	input  wire                   rst_n,
	input  wire arcade_pkg::ps2_key_t   ps2_key,
	input  wire arcade_pkg::ps2_mouse_t ps2_mouse,
	input  wire arcade_pkg::joy_t       joy,
	input  wire             [1:0] enc_pins,  // Bit 0 A, bit 1 B
	input  wire                   hw_fire_n, // Encoder fire button, active low
	input  wire                   hw_enc_en,
	input  wire arcade_pkg::dip_wr_t    dip_wr,
	output arcade_pkg::cab_btn_t        buttons,
	output logic            [1:0] spinner,
	output logic            [7:0] dip_sw,
	output logic                  use_hw
);
	import arcade_pkg::*;

	key_btn_t   key_btn;
	spin_cmd_t  spin_cmd;
	logic [1:0] hw_phase;
	logic [1:0] emu_phase;
	logic       hw_activity;

	//////////////////////////////
	// Blocks
	//////////////////////////////
	key_decoder u_key_decoder (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.key_btn (key_btn)
	);

	encoder_tracker u_encoder_tracker (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.enc_pins    (enc_pins),
		.hw_phase    (hw_phase),
		.hw_activity (hw_activity)
	);

	input_ctrl u_input_ctrl (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.ps2_mouse   (ps2_mouse),
		.joy         (joy),
		.key_btn     (key_btn),
		.hw_phase    (hw_phase),
		.hw_activity (hw_activity),
		.hw_enc_en   (hw_enc_en),
		.hw_fire_n   (hw_fire_n),
		.emu_phase   (emu_phase),
		.spin_cmd    (spin_cmd),
		.buttons     (buttons),
		.spinner     (spinner),
		.use_hw      (use_hw)
	);

	spinner_drive u_spinner_drive (
		.CLK_48M   (CLK_48M),
		.rst_n     (rst_n),
		.spin_cmd  (spin_cmd),
		.emu_phase (emu_phase)
	);

	dip_bank u_dip_bank (
		.CLK_48M (CLK_48M),
		.rst_n   (rst_n),
		.dip_wr  (dip_wr),
		.dip_sw  (dip_sw)
	);

endmodule

`default_nettype wire

/* arcade_pkg.sv */
// Cabinet input shared definitions
`default_nettype none

package arcade_pkg;

	//////////////////////////////
	// Timing
	//////////////////////////////
	localparam int CE_DIV         = 8;      // CLK_48M cycles per 6 MHz enable
	localparam int ENC_SAMPLE_DIV = 4;      // Cycles per encoder sample
	localparam int STEP_TICKS     = 1500;   // Enables per spinner step
	localparam int POLL_TICKS     = 48000;  // Enables per D-pad poll of about 8 ms

	localparam int POS_W      = 12;  // Spinner position width
	localparam int DPAD_SLOW  = 4;
	localparam int DPAD_FAST  = 9;
	localparam int DIP_INDEX  = 254; // Download slot of the DIP bank

	//////////////////////////////
	// PS/2 set 2 make codes
	//////////////////////////////
	localparam logic [7:0] KEY_1     = 8'h16;
	localparam logic [7:0] KEY_2     = 8'h1e;
	localparam logic [7:0] KEY_5     = 8'h2e;
	localparam logic [7:0] KEY_6     = 8'h36;
	localparam logic [7:0] KEY_9     = 8'h46;
	localparam logic [7:0] KEY_P     = 8'h4d;
	localparam logic [7:0] KEY_ALT   = 8'h11;
	localparam logic [7:0] KEY_LEFT  = 8'h6b; // Extended code with E0 prefix dropped upstream
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_SPACE = 8'h29;

	typedef struct packed {
		logic       strobe;  // One cycle per key event
		logic       pressed; // 1 make, 0 break
		logic [7:0] code;
	} ps2_key_t;

	typedef struct packed {
		logic              strobe;
		logic        [1:0] btn;   // Held levels of right and left
		logic signed [8:0] dx;
	} ps2_mouse_t;

	// Right sits in bit 0
	typedef struct packed {
		logic pause;
		logic start2;
		logic coin1;
		logic start1;
		logic fast;
		logic fire;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic service;
		logic pause;
		logic start2;
		logic start1;
		logic coin2;
		logic coin1;
		logic fast;
		logic fire;
		logic right;
		logic left;
	} key_btn_t;

	// Active high toward the game core
	typedef struct packed {
		logic service;
		logic pause;
		logic right;
		logic left;
		logic coin2;
		logic coin1;
		logic start2;
		logic start1;
		logic fast;
		logic fire;
	} cab_btn_t;

	typedef struct packed {
		logic        strobe;
		logic  [7:0] index;
		logic [24:0] addr;
		logic  [7:0] data;
	} dip_wr_t;

	typedef struct packed {
		logic                    add;   // Sum value into position
		logic                    load;  // Overwrite position
		logic                    step;  // Step tick
		logic signed [POS_W-1:0] value;
	} spin_cmd_t;

	// Quadrature sequencer with forward order 00 01 11 10
	function automatic logic [1:0] quad_next(input logic fwd, input logic [1:0] ph);
		logic [1:0] nxt;
		case ({fwd, ph})
			3'b1_00: nxt = 2'b01;
			3'b1_01: nxt = 2'b11;
			3'b1_11: nxt = 2'b10;
			3'b1_10: nxt = 2'b00;
			3'b0_00: nxt = 2'b10;
			3'b0_10: nxt = 2'b11;
			3'b0_11: nxt = 2'b01;
			3'b0_01: nxt = 2'b00;
		endcase
		return nxt;
	endfunction

endpackage

`default_nettype wire

/* dip_bank.sv */
// DIP switch bank
`timescale 1ns/1ps
`default_nettype none

module dip_bank (
	input  wire                      CLK_48M,
	input  wire                      rst_n,
	input  wire arcade_pkg::dip_wr_t dip_wr,
	output logic               [7:0] dip_sw
);
	import arcade_pkg::*;

	logic [7:0] bank [8];  // Stored as downloaded
	logic       hit;

	// Only the first eight bytes of the slot land here
	assign hit = dip_wr.strobe && (dip_wr.index == 8'(DIP_INDEX)) && ((dip_wr.addr >> 3) == '0);

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				bank[i] <= '0;
		end else if (hit) begin
			bank[dip_wr.addr[2:0]] <= dip_wr.data;
		end
	end

	assign dip_sw = ~bank[0];  // Board switches are active low

endmodule

`default_nettype wire

/* encoder_tracker.sv */
// Real quadrature encoder tracker
`timescale 1ns/1ps
`default_nettype none

module encoder_tracker (
	input  wire        CLK_48M,
	input  wire        rst_n,
	input  wire  [1:0] enc_pins,    // B, A
	output logic [1:0] hw_phase,
	output logic       hw_activity
);
	import arcade_pkg::*;

	localparam int SMP_W = $clog2(ENC_SAMPLE_DIV);

	logic [SMP_W-1:0] smp_cnt;
	logic             enc_a_q;   // Last sampled A
	logic [1:0]       pins_q;    // Pins seen last cycle

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			smp_cnt  <= '0;
			enc_a_q  <= 1'b1;  // Pulled up when idle
			hw_phase <= 2'b11;
		end else begin
			smp_cnt <= (smp_cnt == SMP_W'(ENC_SAMPLE_DIV - 1)) ? '0 : smp_cnt + 1'b1;
			if (smp_cnt == '0) begin
				enc_a_q <= enc_pins[0];
				if (enc_a_q != enc_pins[0])  // Edge on A with direction from A xor B
					hw_phase <= quad_next(enc_pins[0] ^ enc_pins[1], hw_phase);
			end
		end
	end

	// Activity detect on every cycle
	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			pins_q      <= 2'b11;
			hw_activity <= 1'b0;
		end else begin
			pins_q      <= enc_pins;
			hw_activity <= pins_q != enc_pins;
		end
	end

	a_gray_step: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		hw_phase != $past(hw_phase) |-> $onehot(hw_phase ^ $past(hw_phase))
	) else $error("encoder phase skipped a state");

endmodule

`default_nettype wire

/* input_ctrl.sv */
// Input control and button merge
`timescale 1ns/1ps
`default_nettype none

module input_ctrl (
	input  wire                         CLK_48M,
	input  wire                         rst_n,
	input  wire arcade_pkg::ps2_mouse_t ps2_mouse,
	input  wire arcade_pkg::joy_t       joy,
	input  wire arcade_pkg::key_btn_t   key_btn,
	input  wire                   [1:0] hw_phase,
	input  wire                         hw_activity,
	input  wire                         hw_enc_en,
	input  wire                         hw_fire_n,
	input  wire                   [1:0] emu_phase,
	output arcade_pkg::spin_cmd_t       spin_cmd,
	output arcade_pkg::cab_btn_t        buttons,
	output logic                  [1:0] spinner,
	output logic                        use_hw
);
	import arcade_pkg::*;

	localparam int CE_W   = $clog2(CE_DIV);
	localparam int STEP_W = $clog2(STEP_TICKS);
	localparam int POLL_W = $clog2(POLL_TICKS);

	logic [CE_W-1:0]         ce_cnt;
	logic                    ce_6m;
	logic [STEP_W-1:0]       step_cnt;
	logic [POLL_W-1:0]       poll_cnt;
	logic                    poll_hit;
	logic                    mouse_pend;     // Delta waiting for next enable
	logic signed [POS_W-1:0] mouse_dx;
	logic signed [POS_W-1:0] mouse_dx_q;
	logic                    mouse_now;
	logic                    pad_left;
	logic                    pad_right;
	logic                    pad_fast;
	logic                    pad_held;
	logic                    pad_run;
	logic                    pad_load;
	logic signed [POS_W-1:0] pad_mag;
	logic signed [POS_W-1:0] pad_val;

	assign mouse_dx  = POS_W'(ps2_mouse.dx);  // Sign extend
	assign mouse_now = ps2_mouse.strobe | mouse_pend;
	assign pad_left  = key_btn.left  | joy.left;
	assign pad_right = key_btn.right | joy.right;
	assign pad_fast  = key_btn.fast  | joy.fast;
	assign pad_held  = pad_left | pad_right;
	assign pad_run   = pad_held & ~mouse_now & ~hw_activity; // Mouse and encoder win
	assign poll_hit  = poll_cnt == POLL_W'(POLL_TICKS - 1);
	assign pad_load  = ce_6m & pad_run & poll_hit;
	assign pad_mag   = pad_fast ? POS_W'(DPAD_FAST) : POS_W'(DPAD_SLOW);
	assign pad_val   = pad_right ? pad_mag : -pad_mag;  // Right wins if both held
	assign ce_6m     = ce_cnt == '0;

	//////////////////////////////
	// Enables and timers
	//////////////////////////////
	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			ce_cnt   <= '0;
			step_cnt <= '0;
			poll_cnt <= '0;
		end else begin
			ce_cnt <= (ce_cnt == CE_W'(CE_DIV - 1)) ? '0 : ce_cnt + 1'b1;
			if (ce_6m) begin
				step_cnt <= (step_cnt == STEP_W'(STEP_TICKS - 1)) ? '0 : step_cnt + 1'b1;
				if (!pad_held)
					poll_cnt <= '0;  // Restart poll on release
				else if (pad_run)
					poll_cnt <= poll_hit ? '0 : poll_cnt + 1'b1;
			end
		end
	end

	// Mouse delta is held until the next enable
	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			mouse_pend <= 1'b0;
		end else if (ce_6m) begin
			mouse_pend <= 1'b0;     // Consumed this cycle
		end else if (ps2_mouse.strobe) begin
			mouse_pend <= 1'b1;
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (ps2_mouse.strobe)
			mouse_dx_q <= mouse_dx;
	end

	//////////////////////////////
	// Source select
	//////////////////////////////
	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			use_hw <= 1'b0;
		end else if (!hw_enc_en) begin
			use_hw <= 1'b0;
		end else if (ps2_mouse.strobe || pad_held) begin
			use_hw <= 1'b0;  // Emulation takes over
		end else if (hw_activity) begin
			use_hw <= 1'b1;
		end
	end

	assign spinner = use_hw ? hw_phase : emu_phase;

	always_comb begin
		spin_cmd.step  = ce_6m & (step_cnt == '0);
		spin_cmd.add   = ce_6m & mouse_now;
		spin_cmd.load  = pad_load;
		if (pad_load)
			spin_cmd.value = pad_val;
		else
			spin_cmd.value = ps2_mouse.strobe ? mouse_dx : mouse_dx_q; // Fresh delta first
	end

	// Button merge
	always_comb begin
		buttons.fire    = key_btn.fire | joy.fire | (|ps2_mouse.btn) | (use_hw & ~hw_fire_n);
		buttons.fast    = pad_fast;
		buttons.start1  = key_btn.start1 | joy.start1;
		buttons.start2  = key_btn.start2 | joy.start2;
		buttons.coin1   = key_btn.coin1  | joy.coin1;
		buttons.coin2   = key_btn.coin2;   // Keyboard only
		buttons.left    = pad_left;
		buttons.right   = pad_right;
		buttons.pause   = key_btn.pause  | joy.pause;
		buttons.service = key_btn.service;
	end

endmodule

`default_nettype wire

/* key_decoder.sv */
// PS/2 key to button decoder
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
	input  wire                       CLK_48M,
	input  wire                       rst_n,
	input  wire arcade_pkg::ps2_key_t ps2_key,
	output arcade_pkg::key_btn_t      key_btn
);
	import arcade_pkg::*;

	logic pressed;

	assign pressed = ps2_key.pressed;

	//////////////////////////////
	// Key map
	//////////////////////////////
	// Each button follows make and break of its key
	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			key_btn <= '0;
		end else if (ps2_key.strobe) begin
			case (ps2_key.code)
				KEY_1:     key_btn.start1  <= pressed;
				KEY_2:     key_btn.start2  <= pressed;
				KEY_5:     key_btn.coin1   <= pressed;
				KEY_6:     key_btn.coin2   <= pressed;
				KEY_9:     key_btn.service <= pressed;
				KEY_P:     key_btn.pause   <= pressed;
				KEY_ALT:   key_btn.fast    <= pressed; // Fast paddle
				KEY_LEFT:  key_btn.left    <= pressed;
				KEY_RIGHT: key_btn.right   <= pressed;
				KEY_SPACE: key_btn.fire    <= pressed;
				default: begin
					// Unmapped codes leave all buttons alone
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* spinner_drive.sv */
// Emulated spinner position and quadrature
`timescale 1ns/1ps
`default_nettype none

module spinner_drive (
	input  wire                        CLK_48M,
	input  wire                        rst_n,
	input  wire arcade_pkg::spin_cmd_t spin_cmd,
	output logic                 [1:0] emu_phase
);
	import arcade_pkg::*;

	logic signed [POS_W-1:0] pos;         // Signed count of steps still owed
	logic signed [POS_W-1:0] pos_stepped;
	logic                    moving;
	logic                    can_add;
	logic                    do_step;

	assign moving  = pos != '0;
	assign can_add = pos[POS_W-1] == pos[POS_W-2]; // Headroom left so no wrap
	assign do_step = spin_cmd.step & moving;

	// One unit toward zero per step
	always_comb begin
		pos_stepped = pos;
		if (do_step)
			pos_stepped = pos[POS_W-1] ? pos + 1'b1 : pos - 1'b1;
	end

	//////////////////////////////
	// Position
	//////////////////////////////
	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			pos <= '0;
		end else if (spin_cmd.load) begin
			pos <= spin_cmd.value;  // D-pad poll
		end else if (spin_cmd.add && can_add) begin
			pos <= pos_stepped + spin_cmd.value;  // Keep a coincident step
		end else begin
			pos <= pos_stepped;
		end
	end

	// Positive position runs forward
	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			emu_phase <= 2'b11;
		end else if (do_step) begin
			emu_phase <= quad_next(~pos[POS_W-1], emu_phase);
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	// Controller keeps D-pad loads off mouse enables
	a_no_load_add: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		!(spin_cmd.load && spin_cmd.add)
	) else $error("spinner load and add in the same cycle");

endmodule

`default_nettype wire

/* src.f */
+incdir+.
arcade_pkg.sv
key_decoder.sv
encoder_tracker.sv
spinner_drive.sv
dip_bank.sv
input_ctrl.sv
arcade_input_top.sv
tb_arcade_input.sv

/* tb_model.svh */
// Testbench reference model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////
// Check
//////////////////////////////
task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
	if (exp_v !== act_v) begin  // X on the DUT side counts as a miss
		err_cnt++;
		$display("error %s expected %0h actual %0h", name, exp_v, act_v);
		$display("*** TEST FAILED ***");
		$fatal(1, "mismatch in %s", name);
	end
endtask

//////////////////////////////
// Reference functions
//////////////////////////////
// Held keyboard buttons after one key event
function automatic key_btn_t key_apply(input key_btn_t k, input ps2_key_t ev);
	key_btn_t n;
	n = k;
	if (ev.strobe) begin
		case (ev.code)
			KEY_1:     n.start1  = ev.pressed;
			KEY_2:     n.start2  = ev.pressed;
			KEY_5:     n.coin1   = ev.pressed;
			KEY_6:     n.coin2   = ev.pressed;
			KEY_9:     n.service = ev.pressed;
			KEY_P:     n.pause   = ev.pressed;
			KEY_ALT:   n.fast    = ev.pressed;
			KEY_LEFT:  n.left    = ev.pressed;
			KEY_RIGHT: n.right   = ev.pressed;
			KEY_SPACE: n.fire    = ev.pressed;
			default:   n = k;  // Unmapped code
		endcase
	end
	return n;
endfunction

// Keyboard OR joystick OR mouse with encoder fire while selected
function automatic cab_btn_t buttons_merge(input key_btn_t k, input joy_t j,
		input logic [1:0] mbtn, input logic hw_sel, input logic fire_n);
	cab_btn_t b;
	b.fire    = k.fire | j.fire | mbtn[0] | mbtn[1] | (hw_sel & ~fire_n);
	b.fast    = k.fast | j.fast;
	b.start1  = k.start1 | j.start1;
	b.start2  = k.start2 | j.start2;
	b.coin1   = k.coin1 | j.coin1;
	b.coin2   = k.coin2;    // No joystick coin2
	b.left    = k.left | j.left;
	b.right   = k.right | j.right;
	b.pause   = k.pause | j.pause;
	b.service = k.service;
	return b;
endfunction

function automatic int step_count_of(input int delta);
	return (delta < 0) ? -delta : delta;
endfunction

function automatic logic step_fwd_of(input int delta);
	return delta > 0;
endfunction

function automatic int dpad_mag_of(input logic fast);
	return fast ? DPAD_FAST : DPAD_SLOW;
endfunction

function automatic logic [7:0] dip_expect(input logic [7:0] byte0);
	return ~byte0;  // Switches read active low
endfunction

// Forward order 00 01 11 10
function automatic logic [1:0] quad_ref(input logic fwd, input logic [1:0] ph);
	logic [1:0] order [4];
	int         i;
	order = '{2'b00, 2'b01, 2'b11, 2'b10};
	i = 0;
	for (int n = 0; n < 4; n++)
		if (order[n] == ph)
			i = n;
	return fwd ? order[(i + 1) % 4] : order[(i + 3) % 4];
endfunction

`endif

/* tb_arcade_input.sv */
// Cabinet input testbench
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_input;
	import arcade_pkg::*;

	localparam int STEP_CYC  = STEP_TICKS * CE_DIV;  // Clocks per spinner step
	localparam int POLL_CYC  = POLL_TICKS * CE_DIV;
	localparam int QUIET_CYC = 2 * STEP_CYC;         // Silence that ends a run
	localparam int MOUSE_RUNS = 3;
	localparam int MOUSE_BUDGET = MOUSE_RUNS * (40 * STEP_CYC + QUIET_CYC + STEP_CYC);
	localparam int DPAD_BUDGET  = 3 * POLL_CYC + (DPAD_FAST + DPAD_SLOW) * STEP_CYC
		+ 2 * (QUIET_CYC + STEP_CYC);
	localparam int WATCHDOG_CYC = MOUSE_BUDGET + DPAD_BUDGET + 50000;

	logic       CLK_48M;
	logic       rst_n;
	ps2_key_t   ps2_key;
	ps2_mouse_t ps2_mouse;
	joy_t       joy;
	logic [1:0] enc_pins;
	logic       hw_fire_n;
	logic       hw_enc_en;
	dip_wr_t    dip_wr;
	cab_btn_t   buttons;
	logic [1:0] spinner;
	logic [7:0] dip_sw;
	logic       use_hw;

	// Model state and compare controls
	integer     seed = 32'hfc97_adf2;
	int         err_cnt = 0;
	key_btn_t   key_m = '0;
	joy_t       joy_m = '0;
	logic [7:0] dip_m [8];
	cab_btn_t   exp_btn = '0;
	logic [7:0] exp_dip = 8'hff;
	logic       btn_chk = 1'b0;
	logic       dip_chk = 1'b0;
	logic       count_en = 1'b0;  // Count spinner steps
	logic       exp_fwd = 1'b1;
	logic [1:0] last_spin = 2'b11;
	int         step_total = 0;

	`include "tb_model.svh"

	arcade_input_top UUT (
		.CLK_48M   (CLK_48M),
		.rst_n     (rst_n),
		.ps2_key   (ps2_key),
		.ps2_mouse (ps2_mouse),
		.joy       (joy),
		.enc_pins  (enc_pins),
		.hw_fire_n (hw_fire_n),
		.hw_enc_en (hw_enc_en),
		.dip_wr    (dip_wr),
		.buttons   (buttons),
		.spinner   (spinner),
		.dip_sw    (dip_sw),
		.use_hw    (use_hw)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #10 CLK_48M = ~CLK_48M;
	end

	//////////////////////////////
	// Compare process
	//////////////////////////////
	always @(negedge CLK_48M) begin  // Outputs settled mid-cycle
		if (rst_n) begin
			if (btn_chk)
				check_val("buttons", exp_btn, buttons);
			if (dip_chk)
				check_val("dip_sw", exp_dip, dip_sw);
			if (spinner !== last_spin && count_en) begin
				check_val("spinner_step", quad_ref(exp_fwd, last_spin), spinner);
				step_total++;
			end
		end
		last_spin = spinner;
	end

	function automatic logic [7:0] mapped_code(input int idx);
		case (idx)
			0: return KEY_1;
			1: return KEY_2;
			2: return KEY_5;
			3: return KEY_6;
			4: return KEY_9;
			5: return KEY_P;
			6: return KEY_ALT;
			7: return KEY_LEFT;
			8: return KEY_RIGHT;
			default: return KEY_SPACE;
		endcase
	endfunction

	// One key strobe plus a new joystick word
	task automatic send_key(input logic pressed, input logic [7:0] code, input joy_t j);
		ps2_key_t ev;
		ev = '{strobe: 1'b1, pressed: pressed, code: code};
		@(posedge CLK_48M);
		btn_chk = 1'b0;
		ps2_key <= ev;
		joy     <= j;
		@(posedge CLK_48M);
		ps2_key <= '0;
		key_m   = key_apply(key_m, ev);
		joy_m   = j;
		exp_btn = buttons_merge(key_m, joy_m, 2'b00, 1'b0, 1'b1);
		btn_chk = 1'b1;  // Checked one cycle after the strobe
		@(negedge CLK_48M);
	endtask

	task automatic write_dip(input logic [7:0] idx, input logic [24:0] addr,
			input logic [7:0] data);
		@(posedge CLK_48M);
		dip_chk = 1'b0;
		dip_wr <= '{strobe: 1'b1, index: idx, addr: addr, data: data};
		@(posedge CLK_48M);
		dip_wr <= '0;
		if (idx == 8'(DIP_INDEX) && addr[24:3] == '0)
			dip_m[addr[2:0]] = data;
		exp_dip = dip_expect(dip_m[0]);
		dip_chk = 1'b1;
		@(negedge CLK_48M);
	endtask

	// Done once the spinner has been still for QUIET_CYC
	task automatic wait_quiet();
		int quiet;
		int seen;
		quiet = 0;
		seen  = step_total;
		while (quiet < QUIET_CYC) begin
			@(negedge CLK_48M);
			if (step_total != seen) begin
				seen  = step_total;
				quiet = 0;
			end else begin
				quiet++;
			end
		end
	endtask

	task automatic mouse_run(input int delta, input logic [1:0] mbtn);
		int start;
		start    = step_total;
		exp_fwd  = step_fwd_of(delta);
		count_en = 1'b1;
		@(posedge CLK_48M);
		ps2_mouse <= '{strobe: 1'b1, btn: mbtn, dx: delta[8:0]};
		@(posedge CLK_48M);
		ps2_mouse <= '0;
		wait_quiet();
		check_val("mouse_steps", step_count_of(delta), step_total - start);
		count_en = 1'b0;
	endtask

	// Hold the D-pad for a number of polls and release
	task automatic dpad_run(input logic right, input logic fast, input int polls);
		joy_t j;
		int   start;
		int   target;
		j        = '0;
		j.right  = right;
		j.left   = ~right;
		j.fast   = fast;
		target   = polls * dpad_mag_of(fast);
		start    = step_total;
		exp_fwd  = right;
		count_en = 1'b1;
		@(posedge CLK_48M);
		joy     <= j;
		exp_btn = buttons_merge(key_m, j, 2'b00, 1'b0, 1'b1);
		while (step_total - start < target)
			@(negedge CLK_48M);
		@(posedge CLK_48M);
		joy     <= '0;
		exp_btn = buttons_merge(key_m, '0, 2'b00, 1'b0, 1'b1);
		wait_quiet();   // Drained with no reload after release
		check_val("dpad_steps", target, step_total - start);
		count_en = 1'b0;
	endtask

	task automatic encoder_run(input int moves);
		logic [1:0] pins;
		logic [1:0] ref_ph;
		pins   = 2'b11;
		ref_ph = 2'b11;
		@(posedge CLK_48M);
		hw_enc_en <= 1'b1;
		for (int k = 0; k < moves; k++) begin
			@(posedge CLK_48M);
			if ($random(seed) & 1) begin
				pins[0] = ~pins[0];   // A edge moves the phase
				ref_ph  = quad_ref(pins[0] ^ pins[1], ref_ph);
			end else begin
				pins[1] = ~pins[1];
			end
			enc_pins <= pins;
			repeat (2 * ENC_SAMPLE_DIV + 2) @(negedge CLK_48M);
			while (use_hw !== 1'b1)
				@(negedge CLK_48M);
			check_val("hw_phase", ref_ph, spinner);
		end
		// Encoder fire only counts while selected
		@(posedge CLK_48M);
		hw_fire_n <= 1'b0;
		exp_btn = buttons_merge(key_m, joy_m, 2'b00, 1'b1, 1'b0);
		btn_chk = 1'b1;
		repeat (4) @(negedge CLK_48M);
		@(posedge CLK_48M);
		btn_chk = 1'b0;
		hw_fire_n <= 1'b1;
		ps2_mouse <= '{strobe: 1'b1, btn: 2'b00, dx: 9'sd0};  // Hands back to emulation
		@(posedge CLK_48M);
		ps2_mouse <= '0;
		@(negedge CLK_48M);
		check_val("use_hw_clear", 0, use_hw);
		@(posedge CLK_48M);
		hw_enc_en <= 1'b0;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		logic [31:0] r;
		rst_n     = 1'b0;
		ps2_key   = '0;
		ps2_mouse = '0;
		joy       = '0;
		enc_pins  = 2'b11;
		hw_fire_n = 1'b1;
		hw_enc_en = 1'b0;
		dip_wr    = '0;
		for (int i = 0; i < 8; i++)
			dip_m[i] = '0;
		repeat (16) @(posedge CLK_48M);
		rst_n <= 1'b1;
		@(negedge CLK_48M);
		check_val("reset_buttons", 0, buttons);
		check_val("reset_spinner", 2'b11, spinner);
		check_val("reset_use_hw", 0, use_hw);
		check_val("reset_dip_sw", 8'hff, dip_sw);

		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			send_key(r[1], r[0] ? mapped_code(r[11:8] % 10) : r[23:16], joy_t'(r[31:24]));
		end
		for (int i = 0; i < 10; i++)
			send_key(1'b0, mapped_code(i), '0);  // Release everything

		for (int i = 0; i < 30; i++) begin
			r = $random(seed);
			write_dip(r[1:0] != 2'b00 ? 8'(DIP_INDEX) : r[15:8],
				r[3:2] == 2'b11 ? {r[31:16], r[8:0]} : {22'd0, r[6:4]}, r[23:16]);
		end
		dip_chk = 1'b0;

		for (int i = 0; i < MOUSE_RUNS; i++)
			mouse_run($random(seed) % 41, 2'b00);
		dpad_run(1'b1, 1'b1, 2);
		dpad_run(1'b0, 1'b0, 1);
		encoder_run(12);

		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYC) @(posedge CLK_48M);
		$display("watchdog expired before all tests finished");
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire
